// ==== sources.f ====
rtl/axi_wr_pkg.sv
rtl/sync_fifo.sv
rtl/axi_write_slave.sv
rtl/local_sram.sv
rtl/axi_mem_top.sv
verification/axi_mem_checker.sv
verification/axi_mem_tb.sv

// ==== verification/axi_mem_tb.sv ====
`timescale 1ns/1ps

module axi_mem_tb import axi_wr_pkg::*; ();

    localparam int FIFO_DEPTH = 4;
    localparam int MEM_WORDS  = 64;
    localparam int TIMEOUT    = 200;

    logic              clk;
    logic              rst_n;
    logic [ID_W-1:0]   awid;
    logic [ADDR_W-1:0] awaddr;
    logic [7:0]        awlen;
    logic [2:0]        awsize;
    burst_e            awburst;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic [ID_W-1:0]   bid;
    resp_e             bresp;
    logic              bvalid;
    logic              bready;
    logic              wb_cyc;
    logic              wb_stb;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_o;
    logic              wb_ack;

    logic [31:0]       seed;
    logic [DATA_W-1:0] shadow [MEM_WORDS];
    logic [DATA_W-1:0] beat_data [16];
    logic [STRB_W-1:0] beat_strb [16];
    int                errors;
    int                test_start;
    int                tests_run;

    axi_mem_top #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_WORDS(MEM_WORDS)) i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // strobes come from the top bits, the low lcg bits repeat too soon.
    task automatic fill_beats(input int n, input bit full_strb);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            beat_data[i] = next_rand();
            r = next_rand();
            beat_strb[i] = full_strb ? '1 : r[31 -: STRB_W];
        end
    endtask

    // every driving task starts and ends 0.5 ns after a rising edge.
    task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input burst_e burst, input logic [7:0] len);
        int cnt;
        awid    = id;
        awaddr  = addr;
        awsize  = 3'd2;
        awburst = burst;
        awlen   = len;
        awvalid = 1'b1;
        cnt = 0;
        while (!awready && cnt < TIMEOUT) begin
            @(posedge clk);
            #0.5;
            cnt++;
        end
        if (!awready) begin
            $display("timeout waiting for awready");
            errors++;
        end
        @(posedge clk);
        #0.5;
        awvalid = 1'b0;
    endtask

    task automatic send_w_burst(input int n);
        int cnt;
        for (int i = 0; i < n; i++) begin
            wdata  = beat_data[i];
            wstrb  = beat_strb[i];
            wlast  = (i == n - 1);
            wvalid = 1'b1;
            cnt = 0;
            while (!wready && cnt < TIMEOUT) begin
                @(posedge clk);
                #0.5;
                cnt++;
            end
            if (!wready) begin
                $display("timeout waiting for wready");
                errors++;
            end
            @(posedge clk);
            #0.5;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic wait_b(output b_item_t got);
        int cnt;
        bready = 1'b1;
        cnt = 0;
        while (!bvalid && cnt < TIMEOUT) begin
            @(posedge clk);
            #0.5;
            cnt++;
        end
        if (!bvalid) begin
            $display("timeout waiting for bvalid");
            errors++;
        end
        got.id   = bid;
        got.resp = bresp;
        @(posedge clk);
        #0.5;
        bready = 1'b0;
    endtask

    task automatic wb_read(input int idx, output logic [DATA_W-1:0] data);
        int cnt;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_adr = ADDR_W'(idx);
        cnt = 0;
        do begin
            @(posedge clk);
            #0.5;
            cnt++;
        end while (!wb_ack && cnt < TIMEOUT);
        if (!wb_ack) begin
            $display("timeout waiting for wb_ack");
            errors++;
        end
        data   = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic compare_resp(input b_item_t got, input b_item_t exp);
        if (got.id !== exp.id) begin
            $display("FAILED bid: got %h expected %h", got.id, exp.id);
            errors++;
        end
        if (got.resp !== exp.resp) begin
            $display("FAILED bresp: got %h expected %h", got.resp, exp.resp);
            errors++;
        end
    endtask

    task automatic compare_word(input int idx, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED wb_dat_o word %0d: got %h expected %h", idx, got, exp);
            errors++;
        end
    endtask

    // beats past the end of memory are dropped by the slave.
    task automatic shadow_burst(input logic [ADDR_W-1:0] addr, input burst_e burst, input int n);
        logic [ADDR_W-1:0] a;
        int                idx;
        a = addr;
        for (int i = 0; i < n; i++) begin
            idx = int'(a >> 2);
            if (idx < MEM_WORDS) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (beat_strb[i][b]) begin
                        shadow[idx][b*8 +: 8] = beat_data[i][b*8 +: 8];
                    end
                end
            end
            if (burst != BURST_FIXED) begin
                a = a + 4;
            end
        end
    endtask

    task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                               input burst_e burst, input int n);
        send_aw(id, addr, burst, 8'(n - 1));
        send_w_burst(n);
        shadow_burst(addr, burst, n);
    endtask

    task automatic expect_resp(input logic [ID_W-1:0] id, input resp_e resp);
        b_item_t got;
        b_item_t exp;
        wait_b(got);
        exp.id   = id;
        exp.resp = resp;
        compare_resp(got, exp);
    endtask

    task automatic check_word(input int idx);
        logic [DATA_W-1:0] got;
        wb_read(idx, got);
        compare_word(idx, got, shadow[idx]);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    task automatic test_single_beat();
        fill_beats(1, 1'b1);
        write_burst(4'h3, 32'h14, BURST_INCR, 1);
        expect_resp(4'h3, RESP_OKAY);
        check_word(5);
        end_test("single beat write");
    endtask

    task automatic test_incr_burst();
        fill_beats(8, 1'b1);
        write_burst(4'h1, 32'h20, BURST_INCR, 8);
        expect_resp(4'h1, RESP_OKAY);
        fill_beats(8, 1'b0);
        write_burst(4'h2, 32'h20, BURST_INCR, 8);
        expect_resp(4'h2, RESP_OKAY);
        for (int i = 8; i < 16; i++) begin
            check_word(i);
        end
        end_test("incr burst with partial strobes");
    endtask

    task automatic test_fixed_burst();
        fill_beats(4, 1'b1);
        // together the strobes cover every lane.
        beat_strb[0] = 4'b0011;
        beat_strb[1] = 4'b1100;
        beat_strb[2] = 4'b0110;
        beat_strb[3] = 4'b1001;
        write_burst(4'h6, 32'h50, BURST_FIXED, 4);
        expect_resp(4'h6, RESP_OKAY);
        check_word(20);
        end_test("fixed burst");
    endtask

    task automatic test_back_pressure();
        logic [ID_W-1:0] ids [3];
        ids = '{4'h7, 4'hA, 4'h5};
        fork
            begin
                for (int k = 0; k < 3; k++) begin
                    fill_beats(2, 1'b1);
                    write_burst(ids[k], 32'h80 + 32'(k * 8), BURST_INCR, 2);
                end
            end
            begin
                for (int i = 8; i < 12; i++) begin
                    check_word(i);
                end
            end
        join
        for (int k = 0; k < 3; k++) begin
            expect_resp(ids[k], RESP_OKAY);
        end
        for (int i = 32; i < 38; i++) begin
            check_word(i);
        end
        end_test("back-pressure with queued responses");
    endtask

    task automatic test_out_of_range();
        fill_beats(1, 1'b1);
        write_burst(4'hB, 32'h0, BURST_INCR, 1);
        expect_resp(4'hB, RESP_OKAY);
        // words 64 and 65 fall outside the memory.
        fill_beats(4, 1'b1);
        write_burst(4'hC, 32'hF8, BURST_INCR, 4);
        expect_resp(4'hC, RESP_SLVERR);
        check_word(62);
        check_word(63);
        check_word(0);
        end_test("burst past end of memory");
    endtask

    initial begin
        seed       = 32'hd3bc4b82;
        errors     = 0;
        test_start = 0;
        tests_run  = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        awid       = '0;
        awaddr     = '0;
        awlen      = '0;
        awsize     = 3'd2;
        awburst    = BURST_INCR;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wlast      = 1'b0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_adr     = '0;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        test_single_beat();
        test_incr_burst();
        test_fixed_burst();
        test_back_pressure();
        test_out_of_range();

        errors += i_dut.i_checker.fail_count;
        $display("summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/axi_mem_checker.sv ====
`timescale 1ns/1ps

module axi_mem_checker import axi_wr_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic [ID_W-1:0]   awid,
    input logic [ADDR_W-1:0] awaddr,
    input logic [2:0]        awsize,
    input burst_e            awburst,
    input logic              awvalid,
    input logic              awready,
    input logic [DATA_W-1:0] wdata,
    input logic [STRB_W-1:0] wstrb,
    input logic              wlast,
    input logic              wvalid,
    input logic              wready,
    input logic [ID_W-1:0]   bid,
    input resp_e             bresp,
    input logic              bvalid,
    input logic              bready,
    input logic              local_wr,
    input logic [ADDR_W-1:0] local_addr,
    input logic [DATA_W-1:0] local_wr_data,
    input logic [STRB_W-1:0] local_wstrb,
    input logic              local_wr_ok,
    input logic              wb_ack
);

    int fail_count = 0;

    // a valid without ready keeps its payload.
    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable({awid, awaddr, awsize, awburst}))
        else begin
            fail_count++;
            $error("aw channel changed before awready");
        end

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable({wdata, wstrb, wlast}))
        else begin
            fail_count++;
            $error("w channel changed before wready");
        end

    b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable({bid, bresp}))
        else begin
            fail_count++;
            $error("b channel changed before bready");
        end

    local_hold: assert property (@(posedge clk) disable iff (!rst_n)
        local_wr && !local_wr_ok |=>
            local_wr && $stable({local_addr, local_wr_data, local_wstrb}))
        else begin
            fail_count++;
            $error("local write dropped or changed before local_wr_ok");
        end

    // outputs idle right after a reset edge.
    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !bvalid && !local_wr && !wb_ack)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

endmodule

bind axi_mem_top axi_mem_checker i_checker (.*);

// ==== rtl/axi_mem_top.sv ====
`timescale 1ns/1ps

module axi_mem_top import axi_wr_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int MEM_WORDS  = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ID_W-1:0]   awid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [7:0]        awlen,
    input  logic [2:0]        awsize,
    input  burst_e            awburst,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    input  logic              wlast,
    input  logic              wvalid,
    output logic              wready,
    output logic [ID_W-1:0]   bid,
    output resp_e             bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic [ADDR_W-1:0] wb_adr,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack
);

    logic              local_wr;
    logic [ADDR_W-1:0] local_addr;
    logic [DATA_W-1:0] local_wr_data;
    logic [STRB_W-1:0] local_wstrb;
    logic              local_wr_ok;

    // awlen stays at the boundary, bursts end on wlast.
    axi_write_slave #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_WORDS(MEM_WORDS)) i_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .awid         (awid),
        .awaddr       (awaddr),
        .awsize       (awsize),
        .awburst      (awburst),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready),
        .bid          (bid),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .local_wr     (local_wr),
        .local_addr   (local_addr),
        .local_wr_data(local_wr_data),
        .local_wstrb  (local_wstrb),
        .local_wr_ok  (local_wr_ok)
    );

    local_sram #(.MEM_WORDS(MEM_WORDS)) i_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .local_wr     (local_wr),
        .local_addr   (local_addr),
        .local_wr_data(local_wr_data),
        .local_wstrb  (local_wstrb),
        .local_wr_ok  (local_wr_ok),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o),
        .wb_ack       (wb_ack)
    );

endmodule

// ==== rtl/local_sram.sv ====
`timescale 1ns/1ps

module local_sram import axi_wr_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              local_wr,
    input  logic [ADDR_W-1:0] local_addr,
    input  logic [DATA_W-1:0] local_wr_data,
    input  logic [STRB_W-1:0] local_wstrb,
    output logic              local_wr_ok,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic [ADDR_W-1:0] wb_adr,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack
);

    localparam int LANE_BITS = $clog2(STRB_W);
    localparam int IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  rd_idx;
    logic              rd_pend;
    logic              wr_en;

    assign wr_idx = local_addr[LANE_BITS +: IDX_W];
    assign rd_idx = wb_adr[IDX_W-1:0];

    // a new read is pending until its ack is out.
    assign rd_pend = wb_cyc && wb_stb && !wb_ack;

    // reads win, the write port waits one cycle.
    assign local_wr_ok = !rd_pend;
    assign wr_en       = local_wr && local_wr_ok;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (local_wstrb[i]) begin
                    mem[wr_idx][i*8 +: 8] <= local_wr_data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            wb_dat_o <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= rd_pend;
        end
    end

endmodule

// ==== rtl/axi_write_slave.sv ====
`timescale 1ns/1ps

module axi_write_slave import axi_wr_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int MEM_WORDS  = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ID_W-1:0]   awid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic [2:0]        awsize,
    input  burst_e            awburst,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    input  logic              wlast,
    input  logic              wvalid,
    output logic              wready,
    output logic [ID_W-1:0]   bid,
    output resp_e             bresp,
    output logic              bvalid,
    input  logic              bready,
    output logic              local_wr,
    output logic [ADDR_W-1:0] local_addr,
    output logic [DATA_W-1:0] local_wr_data,
    output logic [STRB_W-1:0] local_wstrb,
    input  logic              local_wr_ok
);

    localparam int LANE_BITS = $clog2(STRB_W);

    aw_item_t          aw_in;
    aw_item_t          aw_head;
    logic              aw_full;
    logic              aw_empty;
    logic              aw_pop;
    w_item_t           w_in;
    w_item_t           w_head;
    logic              w_full;
    logic              w_empty;
    b_item_t           b_in;
    b_item_t           b_head;
    logic              b_full;
    logic              b_empty;
    logic              beat_avail;
    logic              beat_hold;
    logic              beat_go;
    logic              beat_last;
    logic [ADDR_W-1:0] beat_addr;
    logic [ADDR_W-1:0] beat_step;
    logic [ADDR_W-1:0] word_idx;
    logic              in_range;
    logic              first;
    logic              err_seen;
    logic [ADDR_W-1:0] waddr;

    assign aw_in = '{addr: awaddr, size: awsize, burst: awburst, id: awid};
    assign w_in  = '{data: wdata, strb: wstrb, last: wlast};

    assign awready = !aw_full;
    assign wready  = !w_full;

    sync_fifo #(.item_t(aw_item_t), .FIFO_DEPTH(FIFO_DEPTH)) i_aw_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (awvalid && awready),
        .push_item(aw_in),
        .full     (aw_full),
        .pop      (aw_pop),
        .pop_item (aw_head),
        .empty    (aw_empty)
    );

    sync_fifo #(.item_t(w_item_t), .FIFO_DEPTH(FIFO_DEPTH)) i_w_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (wvalid && wready),
        .push_item(w_in),
        .full     (w_full),
        .pop      (beat_go),
        .pop_item (w_head),
        .empty    (w_empty)
    );

    // last beat of a burst pushes its response.
    sync_fifo #(.item_t(b_item_t), .FIFO_DEPTH(FIFO_DEPTH)) i_b_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (beat_go && beat_last),
        .push_item(b_in),
        .full     (b_full),
        .pop      (bvalid && bready),
        .pop_item (b_head),
        .empty    (b_empty)
    );

    assign beat_avail = !aw_empty && !w_empty;
    assign beat_last  = w_head.last;
    assign beat_addr  = first ? aw_head.addr : waddr;
    assign beat_step  = (aw_head.burst == BURST_FIXED) ? '0 : (ADDR_W'(1) << aw_head.size);
    assign word_idx   = beat_addr >> LANE_BITS;
    assign in_range   = (word_idx < ADDR_W'(MEM_WORDS));

    // no room for the response holds the last beat.
    assign beat_hold = beat_last && b_full;

    // out of range beats retire without touching the memory.
    assign beat_go = beat_avail && !beat_hold && (local_wr_ok || !in_range);
    assign aw_pop  = beat_go && beat_last;

    assign b_in.id   = aw_head.id;
    assign b_in.resp = (err_seen || !in_range) ? RESP_SLVERR : RESP_OKAY;

    assign local_wr      = beat_avail && !beat_hold && in_range;
    assign local_addr    = beat_addr;
    assign local_wr_data = w_head.data;
    assign local_wstrb   = w_head.strb;

    assign bvalid = !b_empty;
    assign bid    = b_head.id;
    assign bresp  = b_head.resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first    <= 1'b1;
            err_seen <= 1'b0;
        end else if (beat_go) begin
            first    <= beat_last;
            err_seen <= !beat_last && (err_seen || !in_range);
        end
    end

    // running beat address, only read once the first beat is gone.
    always_ff @(posedge clk) begin
        if (beat_go && !beat_last) begin
            waddr <= beat_addr + beat_step;
        end
    end

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t     = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_item,
    output logic  full,
    input  logic  pop,
    output item_t pop_item,
    output logic  empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    item_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // a full fifo still accepts a push when the head leaves in the same cycle.
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign pop_item = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== rtl/axi_wr_pkg.sv ====
package axi_wr_pkg;

    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
        burst_e            burst;
        logic [ID_W-1:0]   id;
    } aw_item_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_item_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_item_t;

endpackage
